// File: bs_top.f
+incdir+include
verilog/bs_pkg.sv
verilog/bs_req_fifo.sv
verilog/bs_req_router.sv
verilog/bs_bank_sched.sv
verilog/bs_bank_slice.sv
verilog/bs_bank_arbiter.sv
verilog/bs_top.sv
sim/bs_tb.sv

// File: include/bs_cfg.svh
// Bank count, FIFO geometry, field widths and write watermarks of the bank scheduler
`ifndef BS_CFG_SVH
`define BS_CFG_SVH

// Banks and per-bank source FIFOs
`define BS_BANKS      4
`define BS_RD_FIFOS   2
`define BS_WR_FIFOS   2
`define BS_FIFO_DEPTH 4     // Entries per source FIFO

// Request field widths
`define BS_ROW_W      8     // Row tag
`define BS_SRC_W      2     // Source id
`define BS_DATA_W     16    // Write payload

// Write-mode watermarks, counted over all write FIFOs of one bank
`define BS_WR_HIGH    6     // Enter write mode
`define BS_WR_LOW     2     // Leave write mode once reads wait

`endif

// File: run_sim.sh
#!/bin/sh
# Build the bank scheduler testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module bs_tb \
  -f bs_top.f -Mdir obj_dir -o bs_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/bs_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '^>>> PASS$' sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: sim/bs_tb.sv
// Table-driven testbench for the bank scheduler with reference model, scoreboard and watchdog
`timescale 1ns/1ps
`include "bs_cfg.svh"

module bs_tb;

  localparam int NF = `BS_RD_FIFOS + `BS_WR_FIFOS;  // Model FIFO index, reads first
  localparam int NT = 6;                            // Tests
  localparam int NR = 42;                           // Requests over all tests

  logic         clk, rst_n, req_valid_i, req_full_o, bus_ready_i, cmd_valid_o;
  bs_pkg::req_t req_i;
  bs_pkg::cmd_t cmd_o;

  //**********************************************************
  // Test table, request code 'hKBR
  // K = 4*is_write + src, B = bank, R = row slot of the test
  //**********************************************************
  string       t_name  [NT] = '{"complete", "fifo_order", "row_hit",
                                 "read_prio", "watermark", "full_flag"};
  int          t_len   [NT] = '{8, 6, 8, 6, 8, 6};
  bit          t_hold  [NT] = '{1, 1, 1, 1, 1, 1};  // bus_ready_i low while loading
  bit          t_force [NT] = '{0, 0, 0, 0, 0, 1};  // Strobe even into a full FIFO
  int          t_ncmd  [NT] = '{8, 6, 8, 6, 8, 5};  // Commands expected on the bus
  logic [11:0] t_req   [NR] = '{
    12'h000, 12'h110, 12'h221, 12'h331, 12'h402, 12'h513, 12'h620, 12'h731,  // Mixed
    12'h001, 12'h202, 12'h003, 12'h204, 12'h411, 12'h612,                    // Same FIFO
    12'h015, 12'h115, 12'h016, 12'h115, 12'h116, 12'h437, 12'h537, 12'h437,  // Row hits
    12'h024, 12'h423, 12'h125, 12'h523, 12'h026, 12'h423,                    // Reads first
    12'h036, 12'h137, 12'h430, 12'h531, 12'h432, 12'h533, 12'h434, 12'h535,  // Reads, 6 writes
    12'h100, 12'h300, 12'h101, 12'h302, 12'h103, 12'h000                     // Fill rd FIFO 1
  };

  // Reference model state
  bs_pkg::cmd_t mq       [`BS_BANKS][NF][$];  // Per-bank source FIFOs
  bs_pkg::cmd_t exp_q    [`BS_BANKS][$];      // Expected command order per bank
  bit           mode_m   [`BS_BANKS];         // Write mode register
  int           commit_m [`BS_BANKS];         // Kind of next burst, -1 none
  bs_pkg::row_t rowset   [8];
  integer       seed   = 11343;
  int           errors = 0;
  int           n_pass = 0;
  int           n_fail = 0;
  int           got;

  bs_top uut (
    .clk(clk), .rst_n(rst_n),
    .req_valid_i(req_valid_i), .req_i(req_i), .req_full_o(req_full_o),
    .bus_ready_i(bus_ready_i),
    .cmd_valid_o(cmd_valid_o), .cmd_o(cmd_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;   // 8 ns period
  end

  // Run limit from total request count
  initial begin : watchdog
    int limit;
    limit = 16;
    for (int t = 0; t < NT; t++) limit += t_len[t] * 20;
    repeat (limit) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", limit);
    $display(">>> FAIL");
    $finish;
  end

  function automatic int fifo_of(input bs_pkg::req_t r);
    return r.is_write ? `BS_RD_FIFOS + r.src % `BS_WR_FIFOS : r.src % `BS_RD_FIFOS;
  endfunction

  function automatic int wr_queued(input int b);
    int n = 0;
    for (int i = `BS_RD_FIFOS; i < NF; i++) n += mq[b][i].size();
    return n;
  endfunction

  function automatic bit rd_queued(input int b);
    bit any = 1'b0;
    for (int i = 0; i < `BS_RD_FIFOS; i++) any |= (mq[b][i].size() > 0);
    return any;
  endfunction

  function automatic bit has_work(input int b, input bit wr_mode);
    return wr_mode ? (wr_queued(b) > 0) : rd_queued(b);
  endfunction

  // Watermark rule, value holds between the marks
  task automatic update_mode(input int b);
    if (wr_queued(b) >= `BS_WR_HIGH || (!rd_queued(b) && wr_queued(b) > 0)) mode_m[b] = 1'b1;
    else if (wr_queued(b) <= `BS_WR_LOW && rd_queued(b)) mode_m[b] = 1'b0;
  endtask

  // Idle scheduler sees new entry with the old mode first, then the updated one
  task automatic model_push(input bs_pkg::req_t r);
    bs_pkg::cmd_t c;
    int           b;
    bit           old;
    c          = '0;
    c.is_write = r.is_write;
    c.bank     = r.bank;
    c.src      = r.src;
    c.row      = r.row;
    c.data     = r.is_write ? r.data : '0;   // Reads carry no data
    b          = r.bank;
    mq[b][fifo_of(r)].push_back(c);
    old = mode_m[b];
    if (commit_m[b] < 0 && has_work(b, old)) commit_m[b] = int'(old);
    update_mode(b);
    if (commit_m[b] < 0 && has_work(b, mode_m[b])) commit_m[b] = int'(mode_m[b]);
  endtask

  //**********************************************************
  // Burst order of one bank: lowest FIFO first, then row hits
  //**********************************************************
  task automatic model_drain(input int b);
    bs_pkg::cmd_t c;
    bs_pkg::row_t row;
    int           base, last, f;
    bit           first;
    while (commit_m[b] >= 0) begin
      base  = commit_m[b] ? `BS_RD_FIFOS : 0;
      last  = commit_m[b] ? NF : `BS_RD_FIFOS;
      first = 1'b1;
      f     = 0;
      row   = '0;
      while (f >= 0) begin
        f = -1;
        for (int i = last - 1; i >= base; i--) begin
          if (mq[b][i].size() > 0 && (first || mq[b][i][0].row == row)) f = i;
        end
        if (f >= 0) begin
          c             = mq[b][f].pop_front();
          c.burst_start = first;
          row           = c.row;
          first         = 1'b0;
          exp_q[b].push_back(c);
          update_mode(b);          // Mode register tracks every pop
        end
      end
      update_mode(b);
      commit_m[b] = has_work(b, mode_m[b]) ? int'(mode_m[b]) : -1;   // Mode at burst end
    end
  endtask

  // Present the request, sample the full level, then strobe
  task automatic send_req(input bs_pkg::req_t r, input bit force_strobe, input string name);
    logic full_now;
    bit   full_exp;
    @(posedge clk);
    req_i       <= r;
    req_valid_i <= 1'b0;
    @(negedge clk);
    full_now = req_full_o;
    full_exp = mq[r.bank][fifo_of(r)].size() >= `BS_FIFO_DEPTH;
    assert (full_now == full_exp) else begin
      $display("FAIL %s req_full expected %0d actual %0d", name, full_exp, full_now);
      errors++;
    end
    @(posedge clk);
    req_valid_i <= !full_now || force_strobe;
    if ((!full_now || force_strobe) && !full_exp) model_push(r);   // Full strobe is dropped
  endtask

  // One bus sample, scored against the bank's expected order
  task automatic sample_bus(input string name);
    bs_pkg::cmd_t e;
    @(negedge clk);
    if (cmd_valid_o) begin
      got++;
      assert (exp_q[cmd_o.bank].size() != 0) else begin
        $display("%s: unexpected command from bank %0d, row %h", name, cmd_o.bank, cmd_o.row);
        errors++;
      end
      if (exp_q[cmd_o.bank].size() != 0) begin
        e = exp_q[cmd_o.bank].pop_front();
        assert (cmd_o == e) else begin
          $display("FAIL %s expected %h actual %h", name, e, cmd_o);
          errors++;
        end
      end
    end
  endtask

  //**********************************************************
  // Main sequence
  //**********************************************************
  initial begin : main
    bs_pkg::req_t r;
    logic [11:0]  code;
    int           idx, total, err0;
    rst_n       = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    bus_ready_i = 1'b0;
    for (int b = 0; b < `BS_BANKS; b++) begin
      mode_m[b]   = 1'b0;   // Read mode after reset
      commit_m[b] = -1;
    end
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);
    idx = 0;
    for (int t = 0; t < NT; t++) begin
      err0 = errors;
      for (int i = 0; i < 8; i++) rowset[i] = {5'($random(seed)), 3'(i)};  // Distinct rows
      bus_ready_i <= !t_hold[t];
      for (int i = 0; i < t_len[t]; i++) begin
        code       = t_req[idx + i];
        r.is_write = code[10];
        r.src      = code[9:8];
        r.bank     = code[5:4];
        r.row      = rowset[code[2:0]];
        r.data     = bs_pkg::data_t'($random(seed));
        send_req(r, t_force[t], t_name[t]);
      end
      idx += t_len[t];
      @(posedge clk);
      req_valid_i <= 1'b0;
      repeat (4) @(posedge clk);   // Let idle schedulers commit
      total = 0;
      for (int b = 0; b < `BS_BANKS; b++) begin
        model_drain(b);
        total += exp_q[b].size();
      end
      bus_ready_i <= 1'b1;
      got = 0;
      while (got < total) sample_bus(t_name[t]);
      repeat (16) sample_bus(t_name[t]);   // Window for stray commands
      @(posedge clk);
      bus_ready_i <= 1'b0;
      for (int b = 0; b < `BS_BANKS; b++) begin
        assert (exp_q[b].size() == 0) else begin
          $display("%s: %0d commands never left bank %0d", t_name[t], exp_q[b].size(), b);
          errors++;
          exp_q[b].delete();
        end
      end
      assert (got == t_ncmd[t]) else begin
        $display("FAIL %s command count expected %0d actual %0d", t_name[t], t_ncmd[t], got);
        errors++;
      end
      if (errors == err0) n_pass++;
      else n_fail++;
      $display("Test %0d %s: %0d requests, %0d commands, %s", t, t_name[t], t_len[t], got,
               (errors == err0) ? "ok" : "errors");
    end
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d failed checks",
             NT, n_pass, n_fail, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: verilog/bs_bank_arbiter.sv
// Round-robin bank arbiter with burst-long grant lock and registered command output
`timescale 1ns/1ps
`include "bs_cfg.svh"

module bs_bank_arbiter (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              bus_ready_i,  // New grants only while high
  input  logic [`BS_BANKS-1:0]              valid_i,
  input  bs_pkg::cmd_t [`BS_BANKS-1:0]      cmd_i,
  output logic [`BS_BANKS-1:0]              ready_o,
  output logic                              cmd_valid_o,
  output bs_pkg::cmd_t                      cmd_o
);

  bs_pkg::bank_t rr_q;       // Round-robin start point
  bs_pkg::bank_t gnt_q;      // Locked bank
  logic          lock_q;     // A burst is running
  bs_pkg::bank_t pick, sel;
  logic          found, grant_new, fire;

  // First requesting bank at or after the pointer
  always_comb begin : p_pick
    bs_pkg::bank_t idx;
    pick  = rr_q;
    found = 1'b0;
    for (int k = 0; k < `BS_BANKS; k++) begin
      idx = bs_pkg::bank_t'((rr_q + k) % `BS_BANKS);
      if (!found && valid_i[idx]) begin
        pick  = idx;
        found = 1'b1;
      end
    end
  end

  assign grant_new = !lock_q && bus_ready_i && found;
  assign sel       = lock_q ? gnt_q : pick;

  always_comb begin
    ready_o = '0;
    if (lock_q || grant_new) ready_o[sel] = 1'b1;   // Held through the burst
  end

  assign fire = |(ready_o & valid_i);   // Pop in the granted slice

  //**********************************************************
  // Lock, pointer and output register
  //**********************************************************
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rr_q        <= '0;
      gnt_q       <= '0;
      lock_q      <= 1'b0;
      cmd_valid_o <= 1'b0;
    end else begin
      cmd_valid_o <= fire;
      if (grant_new) begin
        lock_q <= 1'b1;
        gnt_q  <= pick;
      end else if (lock_q && !valid_i[gnt_q]) begin
        lock_q <= 1'b0;                         // Valid low marks end of burst
        rr_q   <= (gnt_q == bs_pkg::bank_t'(`BS_BANKS-1)) ? '0 : gnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) cmd_o <= cmd_i[sel];
  end

endmodule

// File: verilog/bs_bank_sched.sv
// Per-bank burst scheduler FSM with read/write mode and row-hit bursting
`timescale 1ns/1ps
`include "bs_cfg.svh"

module bs_bank_sched (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 write_mode_i,  // Slice mode, used at burst start
  input  logic [`BS_RD_FIFOS-1:0]              rd_empty_i,
  input  logic [`BS_WR_FIFOS-1:0]              wr_empty_i,
  input  bs_pkg::rd_entry_t [`BS_RD_FIFOS-1:0] rd_head_i,
  input  bs_pkg::wr_entry_t [`BS_WR_FIFOS-1:0] wr_head_i,
  input  logic                                 ready_i,       // Grant from bank arbiter
  output logic [`BS_RD_FIFOS-1:0]              rd_pop_o,
  output logic [`BS_WR_FIFOS-1:0]              wr_pop_o,
  output logic                                 valid_o,
  output bs_pkg::cmd_t                         cmd_o          // Bank field filled by slice
);

  localparam int SEL_N = (`BS_RD_FIFOS > `BS_WR_FIFOS) ? `BS_RD_FIFOS : `BS_WR_FIFOS;

  typedef enum logic [2:0] {
    S_IDLE,
    S_WAIT,       // Burst requested, waiting for the grant
    S_RD_BURST,
    S_WR_BURST,
    S_FINISH      // One cycle with valid low, ends the grant
  } state_t;

  state_t                  state_q, state_d;
  logic                    wr_burst_q, wr_burst_d;  // Kind of current burst
  bs_pkg::row_t            row_q, row_d;            // Row tag of current burst
  logic [`BS_RD_FIFOS-1:0] rd_hit, rd_cand;
  logic [`BS_WR_FIFOS-1:0] wr_hit, wr_cand;
  int unsigned             rd_sel, wr_sel;
  logic                    start_ok;

  // Lowest set bit wins, zero when nothing is set
  function automatic int unsigned low_idx(input logic [SEL_N-1:0] vec);
    int unsigned idx = 0;
    for (int i = SEL_N-1; i >= 0; i--) begin
      if (vec[i]) idx = i;
    end
    return idx;
  endfunction

  //**********************************************************
  // Row hits and head selection
  //**********************************************************
  always_comb begin
    for (int i = 0; i < `BS_RD_FIFOS; i++) begin
      rd_hit[i] = !rd_empty_i[i] && (rd_head_i[i].row == row_q);
    end
    for (int i = 0; i < `BS_WR_FIFOS; i++) begin
      wr_hit[i] = !wr_empty_i[i] && (wr_head_i[i].row == row_q);
    end
  end

  // First pop takes any head, later pops only row hits
  assign rd_cand = (state_q == S_WAIT) ? ~rd_empty_i : rd_hit;
  assign wr_cand = (state_q == S_WAIT) ? ~wr_empty_i : wr_hit;
  assign rd_sel  = low_idx(SEL_N'(rd_cand));
  assign wr_sel  = low_idx(SEL_N'(wr_cand));

  // Work queued for the mode the slice currently asks for
  assign start_ok = write_mode_i ? !(&wr_empty_i) : !(&rd_empty_i);

  //**********************************************************
  // Next state and pops
  //**********************************************************
  always_comb begin
    state_d    = state_q;
    wr_burst_d = wr_burst_q;
    row_d      = row_q;
    valid_o    = 1'b0;
    rd_pop_o   = '0;
    wr_pop_o   = '0;
    case (state_q)
      S_IDLE, S_FINISH: begin
        if (start_ok) begin
          state_d    = S_WAIT;
          wr_burst_d = write_mode_i;   // Mode frozen for the whole burst
        end else begin
          state_d    = S_IDLE;
        end
      end
      S_WAIT: begin
        valid_o = 1'b1;                // Only this FSM pops, heads stay put
        if (ready_i && wr_burst_q) begin
          wr_pop_o[wr_sel] = 1'b1;
          row_d            = wr_head_i[wr_sel].row;
          state_d          = S_WR_BURST;
        end else if (ready_i) begin
          rd_pop_o[rd_sel] = 1'b1;
          row_d            = rd_head_i[rd_sel].row;
          state_d          = S_RD_BURST;
        end
      end
      S_RD_BURST: begin
        if (|rd_hit) begin
          valid_o          = 1'b1;
          rd_pop_o[rd_sel] = ready_i;
        end else begin
          state_d = S_FINISH;          // No hit left
        end
      end
      S_WR_BURST: begin
        if (|wr_hit) begin
          valid_o          = 1'b1;
          wr_pop_o[wr_sel] = ready_i;
        end else begin
          state_d = S_FINISH;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  // Command built from the head that is popped
  always_comb begin
    cmd_o             = '0;
    cmd_o.is_write    = wr_burst_q;
    cmd_o.burst_start = (state_q == S_WAIT);
    if (wr_burst_q) begin
      cmd_o.src  = wr_head_i[wr_sel].src;
      cmd_o.row  = wr_head_i[wr_sel].row;
      cmd_o.data = wr_head_i[wr_sel].data;
    end else begin
      cmd_o.src  = rd_head_i[rd_sel].src;
      cmd_o.row  = rd_head_i[rd_sel].row;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q    <= S_IDLE;
      wr_burst_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      wr_burst_q <= wr_burst_d;
    end
  end

  always_ff @(posedge clk) begin
    row_q <= row_d;
  end

endmodule

// File: verilog/bs_bank_slice.sv
// One bank: read and write source FIFOs, write-watermark mode register, burst scheduler
`timescale 1ns/1ps
`include "bs_cfg.svh"

module bs_bank_slice #(
  parameter int BANK_ID = 0
) (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic [`BS_RD_FIFOS-1:0]                  rd_push_i,
  input  logic [`BS_WR_FIFOS-1:0]                  wr_push_i,
  input  bs_pkg::rd_entry_t                        rd_entry_i,
  input  bs_pkg::wr_entry_t                        wr_entry_i,
  output logic [`BS_RD_FIFOS+`BS_WR_FIFOS-1:0]     full_o,     // Reads low, writes high
  input  logic                                     ready_i,
  output logic                                     valid_o,
  output bs_pkg::cmd_t                             cmd_o
);

  localparam int CNT_W = $clog2(`BS_FIFO_DEPTH+1);
  localparam int SUM_W = $clog2(`BS_WR_FIFOS*`BS_FIFO_DEPTH+1);

  logic [`BS_RD_FIFOS-1:0]              rd_empty, rd_full, rd_pop;
  logic [`BS_WR_FIFOS-1:0]              wr_empty, wr_full, wr_pop;
  bs_pkg::rd_entry_t [`BS_RD_FIFOS-1:0] rd_head;
  bs_pkg::wr_entry_t [`BS_WR_FIFOS-1:0] wr_head;
  logic [`BS_WR_FIFOS-1:0][CNT_W-1:0]   wr_count;
  logic [SUM_W-1:0]                     wr_sum;     // Writes queued in this bank
  logic                                 rd_any, wr_any;
  logic                                 write_mode_q;
  bs_pkg::cmd_t                         sched_cmd;

  for (genvar i = 0; i < `BS_RD_FIFOS; i++) begin : g_rd_fifo
    bs_req_fifo #(.entry_t(bs_pkg::rd_entry_t), .DEPTH(`BS_FIFO_DEPTH)) u_fifo (
      .clk(clk), .rst_n(rst_n),
      .push_i(rd_push_i[i]), .din_i(rd_entry_i), .pop_i(rd_pop[i]),
      .head_o(rd_head[i]), .empty_o(rd_empty[i]), .full_o(rd_full[i]), .count_o()
    );
  end

  for (genvar i = 0; i < `BS_WR_FIFOS; i++) begin : g_wr_fifo
    bs_req_fifo #(.entry_t(bs_pkg::wr_entry_t), .DEPTH(`BS_FIFO_DEPTH)) u_fifo (
      .clk(clk), .rst_n(rst_n),
      .push_i(wr_push_i[i]), .din_i(wr_entry_i), .pop_i(wr_pop[i]),
      .head_o(wr_head[i]), .empty_o(wr_empty[i]), .full_o(wr_full[i]),
      .count_o(wr_count[i])
    );
  end

  assign full_o = {wr_full, rd_full};
  assign rd_any = !(&rd_empty);
  assign wr_any = !(&wr_empty);

  always_comb begin
    wr_sum = '0;
    for (int i = 0; i < `BS_WR_FIFOS; i++) begin
      wr_sum = wr_sum + SUM_W'(wr_count[i]);
    end
  end

  //**********************************************************
  // Write-mode register with watermarks
  //**********************************************************
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      write_mode_q <= 1'b0;                                     // Read mode after reset
    end else if (wr_sum >= SUM_W'(`BS_WR_HIGH) || (!rd_any && wr_any)) begin
      write_mode_q <= 1'b1;                                     // High mark or reads idle
    end else if (wr_sum <= SUM_W'(`BS_WR_LOW) && rd_any) begin
      write_mode_q <= 1'b0;
    end
  end

  bs_bank_sched u_sched (
    .clk(clk), .rst_n(rst_n),
    .write_mode_i(write_mode_q),
    .rd_empty_i(rd_empty), .wr_empty_i(wr_empty),
    .rd_head_i(rd_head), .wr_head_i(wr_head),
    .ready_i(ready_i),
    .rd_pop_o(rd_pop), .wr_pop_o(wr_pop),
    .valid_o(valid_o), .cmd_o(sched_cmd)
  );

  always_comb begin
    cmd_o      = sched_cmd;
    cmd_o.bank = bs_pkg::bank_t'(BANK_ID);   // Own bank number
  end

endmodule

// File: verilog/bs_pkg.sv
// Field, request, stored-entry and memory-command types of the bank scheduler
`include "bs_cfg.svh"

package bs_pkg;

  // Field types
  typedef logic [$clog2(`BS_BANKS)-1:0] bank_t;
  typedef logic [`BS_SRC_W-1:0]         src_t;
  typedef logic [`BS_ROW_W-1:0]         row_t;
  typedef logic [`BS_DATA_W-1:0]        data_t;

  // Request on the input port, bank already decoded
  typedef struct packed {
    logic  is_write;
    src_t  src;
    bank_t bank;
    row_t  row;
    data_t data;   // Don't care for reads
  } req_t;

  // Read FIFO entry
  typedef struct packed {
    src_t src;
    row_t row;
  } rd_entry_t;

  // Write FIFO entry
  typedef struct packed {
    src_t  src;
    row_t  row;
    data_t data;
  } wr_entry_t;

  // Command towards the memory side
  typedef struct packed {
    logic  is_write;
    logic  burst_start;  // First command of a row-hit burst
    bank_t bank;
    src_t  src;
    row_t  row;
    data_t data;
  } cmd_t;

endpackage

// File: verilog/bs_req_fifo.sv
// Circular-buffer request FIFO with a type-parameterized entry
`timescale 1ns/1ps

module bs_req_fifo #(
  parameter type entry_t = logic [7:0],
  parameter int  DEPTH   = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       push_i,   // Ignored when full
  input  entry_t                     din_i,
  input  logic                       pop_i,    // Ignored when empty
  output entry_t                     head_o,   // Oldest entry, valid while not empty
  output logic                       empty_o,
  output logic                       full_o,
  output logic [$clog2(DEPTH+1)-1:0] count_o   // Occupancy
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH+1);

  entry_t             mem_q [DEPTH];  // Storage, no reset
  logic [PTR_W-1:0]   wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0]   count_q;
  logic               do_push, do_pop;

  // Wrap at DEPTH, works for any depth
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH-1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign count_o = count_q;
  assign head_o  = mem_q[rd_ptr_q];       // Combinational head, pop is same cycle

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk) begin
    if (do_push) mem_q[wr_ptr_q] <= din_i;
  end

  //**********************************************************
  // Pointers and occupancy
  //**********************************************************
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (do_pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;                          // Idle or push and pop together
      endcase
    end
  end

endmodule

// File: verilog/bs_req_router.sv
// Request router that steers each request to its bank and source FIFO
`timescale 1ns/1ps
`include "bs_cfg.svh"

module bs_req_router (
  input  logic                                                    req_valid_i,  // Strobe
  input  bs_pkg::req_t                                            req_i,
  input  logic [`BS_BANKS-1:0][`BS_RD_FIFOS+`BS_WR_FIFOS-1:0]     full_i,
  output logic [`BS_BANKS-1:0][`BS_RD_FIFOS-1:0]                  rd_push_o,
  output logic [`BS_BANKS-1:0][`BS_WR_FIFOS-1:0]                  wr_push_o,
  output bs_pkg::rd_entry_t                                       rd_entry_o,   // Broadcast
  output bs_pkg::wr_entry_t                                       wr_entry_o,   // Broadcast
  output logic                                                    req_full_o
);

  int unsigned rd_sel, wr_sel;  // Source FIFO inside its kind
  int unsigned fifo_sel;        // Index into the slice full vector, reads first
  logic        accept;

  always_comb begin
    rd_sel   = req_i.src % `BS_RD_FIFOS;
    wr_sel   = req_i.src % `BS_WR_FIFOS;
    fifo_sel = req_i.is_write ? `BS_RD_FIFOS + wr_sel : rd_sel;
  end

  // Full level of the FIFO the request on the port is aimed at
  assign req_full_o = full_i[req_i.bank][fifo_sel];
  assign accept     = req_valid_i && !req_full_o;  // Strobe into a full FIFO is dropped

  //**********************************************************
  // One-hot push decode
  //**********************************************************
  always_comb begin
    for (int b = 0; b < `BS_BANKS; b++) begin
      for (int f = 0; f < `BS_RD_FIFOS; f++) begin
        rd_push_o[b][f] = accept && !req_i.is_write && (req_i.bank == b) && (rd_sel == f);
      end
      for (int f = 0; f < `BS_WR_FIFOS; f++) begin
        wr_push_o[b][f] = accept && req_i.is_write && (req_i.bank == b) && (wr_sel == f);
      end
    end
  end

  // Entries go to every slice, only the push bit selects
  assign rd_entry_o = '{src: req_i.src, row: req_i.row};
  assign wr_entry_o = '{src: req_i.src, row: req_i.row, data: req_i.data};

endmodule

// File: verilog/bs_top.sv
// Bank scheduler top: request router, per-bank slices, bank arbiter
`timescale 1ns/1ps
`include "bs_cfg.svh"

module bs_top (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         req_valid_i,
  input  bs_pkg::req_t req_i,
  output logic         req_full_o,    // Requester must not strobe while high
  input  logic         bus_ready_i,
  output logic         cmd_valid_o,
  output bs_pkg::cmd_t cmd_o
);

  logic [`BS_BANKS-1:0][`BS_RD_FIFOS+`BS_WR_FIFOS-1:0] full;
  logic [`BS_BANKS-1:0][`BS_RD_FIFOS-1:0]              rd_push;
  logic [`BS_BANKS-1:0][`BS_WR_FIFOS-1:0]              wr_push;
  bs_pkg::rd_entry_t                                   rd_entry;
  bs_pkg::wr_entry_t                                   wr_entry;
  logic [`BS_BANKS-1:0]                                sched_valid, sched_ready;
  bs_pkg::cmd_t [`BS_BANKS-1:0]                        sched_cmd;

  bs_req_router u_router (
    .req_valid_i(req_valid_i), .req_i(req_i), .full_i(full),
    .rd_push_o(rd_push), .wr_push_o(wr_push),
    .rd_entry_o(rd_entry), .wr_entry_o(wr_entry),
    .req_full_o(req_full_o)
  );

  // One slice per bank
  for (genvar b = 0; b < `BS_BANKS; b++) begin : g_bank
    bs_bank_slice #(.BANK_ID(b)) u_slice (
      .clk(clk), .rst_n(rst_n),
      .rd_push_i(rd_push[b]), .wr_push_i(wr_push[b]),
      .rd_entry_i(rd_entry), .wr_entry_i(wr_entry),
      .full_o(full[b]),
      .ready_i(sched_ready[b]), .valid_o(sched_valid[b]), .cmd_o(sched_cmd[b])
    );
  end

  bs_bank_arbiter u_arbiter (
    .clk(clk), .rst_n(rst_n), .bus_ready_i(bus_ready_i),
    .valid_i(sched_valid), .cmd_i(sched_cmd), .ready_o(sched_ready),
    .cmd_valid_o(cmd_valid_o), .cmd_o(cmd_o)
  );

endmodule
